// ==== design/bus_strobe_sync.sv ====
/*
 * z80 I/O strobe sampler: takes iorq/wr/rd on zpos and
 * gives one-fclk write and read pulses per bus cycle
 */

module bus_strobe_sync (
	input  logic fclk,
	input  logic rst_n,
	input  logic zpos,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	output logic port_wr,
	output logic port_rd
);

	// bit 0 write, bit 1 read
	logic [1:0] req;
	logic [1:0] smp0;  // zpos-gated first stage
	logic [1:0] smp1;  // retimed
	logic [1:0] seen;  // previous smp1 for edge detect

	assign req = {~(iorq_n | rd_n), ~(iorq_n | wr_n)};

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			smp0    <= 2'b00;
			smp1    <= 2'b00;
			seen    <= 2'b00;
			port_wr <= 1'b0;
			port_rd <= 1'b0;
		end
		else
		begin
			if (zpos)
				smp0 <= req; // z80 bus only valid around zpos
			smp1 <= smp0;
			seen <= smp1;
			// rising edge only, one pulse per z80 cycle
			port_wr <= smp1[0] & ~seen[0];
			port_rd <= smp1[1] & ~seen[1];
		end
	end

endmodule

// ==== design/config_pkg.sv ====
/*
 * config fields: BF bit layout, paging register bits,
 * reset values and ULAplus group codes
 */

package config_pkg;

	// BF byte, bit 2 reads back as 0
	localparam int BF_SHADOW = 0;
	localparam int BF_ROMRW  = 1;
	localparam int BF_NMI    = 3;
	localparam int BF_BRK    = 4;

	localparam int PAGE_LOCK_BIT = 5; // 7FFD 48k lock

	localparam int EFF7_BLOCK1M = 2;
	localparam int EFF7_RAM0    = 3;

	localparam logic [7:0] PAGE_RST     = 8'h00;
	localparam logic [7:0] EFF7_1M_MASK = 8'b1011_0001; // bits 6,3,2,1 cleared in 1M mode

	typedef logic [3:0] border_t;

	// what the next data write on 3B goes to
	typedef enum logic {
		ula_palette = 1'b0,
		ula_mode    = 1'b1
	} ula_mode_t;

	localparam logic [1:0] ULA_GROUP_PALETTE = 2'b00;
	localparam logic [1:0] ULA_GROUP_MODE    = 2'b01;

endpackage

// ==== design/evo_config_regs.sv ====
/*
 * evo config registers: BF bits, border, break address,
 * nmi and beeper strobes, ULAplus palette and mode
 */

module evo_config_regs
	import port_map_pkg::*;
	import config_pkg::*;
(
	input  logic        fclk,
	input  logic        rst_n,
	input  logic        port_wr,
	input  port_sel_t   port_sel,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	output logic        shadow_en,
	output logic        romrw_en,
	output logic        set_nmi,
	output logic        brk_ena,
	output logic [15:0] brk_addr,
	output border_t     border,
	output logic        beeper_wr,
	output logic        clr_nmi,
	output logic        up_ena,
	output logic [5:0]  up_paladdr,
	output logic [7:0]  up_paldata,
	output logic        up_palwr,
	output logic [7:0]  up_lastwritten
);

	logic      up_wr;
	ula_mode_t up_sel; // target of 3B data writes
	bd_index_t bd_idx;

	assign bd_idx = bd_index_t'(a[12:8]);
	assign up_wr  = port_wr && (port_sel == sel_ulaplus);

	//////////////////////////////////////////////////////////////////////////
	// BF, FE and BD writes
	//////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			shadow_en <= 1'b0;
			romrw_en  <= 1'b0;
			set_nmi   <= 1'b0;
			brk_ena   <= 1'b0;
			border    <= '0;
			brk_addr  <= 16'h0000;
		end
		else if (port_wr)
		begin
			if (port_sel == sel_bf)
			begin
				shadow_en <= din[BF_SHADOW];
				romrw_en  <= din[BF_ROMRW];
				set_nmi   <= din[BF_NMI];
				brk_ena   <= din[BF_BRK];
			end
			if (port_sel == sel_fe)
				border <= {~a[3], din[2:0]}; // bright bit from the address
			if (port_sel == sel_bd && bd_idx == bd_lobrk)
				brk_addr[7:0] <= din;
			if (port_sel == sel_bd && bd_idx == bd_hibrk)
				brk_addr[15:8] <= din;
		end
	end

	// strobes straight from the write pulse
	assign beeper_wr = port_wr && (port_sel == sel_fe) && (a[7:0] == PORT_FE); // not on aliases
	assign clr_nmi   = port_wr && (port_sel == sel_be);

	//////////////////////////////////////////////////////////////////////////
	// ULAplus
	//////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			up_sel <= ula_palette;
			up_ena <= 1'b0;
		end
		else if (up_wr)
		begin
			if (!a[14] && din[7:6] == ULA_GROUP_MODE)
				up_sel <= ula_mode;
			else if (!a[14] && din[7:6] == ULA_GROUP_PALETTE)
				up_sel <= ula_palette;
			if (a[14] && up_sel == ula_mode)
				up_ena <= din[0];
		end
	end

	always_ff @(posedge fclk)
	begin
		if (up_wr && !a[14] && din[7:6] == ULA_GROUP_PALETTE)
			up_paladdr <= din[5:0]; // palette entry for next data write
		if (up_wr && a[14])
			up_lastwritten <= din;
	end

	assign up_palwr   = up_wr && a[14] && (up_sel == ula_palette);
	assign up_paldata = {din[4:2], din[7:5], din[1:0]}; // G3R3B2 to R3G3B2

endmodule

// ==== design/paging_regs.sv ====
/*
 * memory paging registers 7FFD and EFF7, with the 128k lock
 * and the 1M-mode masking of the exported values
 */

module paging_regs
	import port_map_pkg::*;
	import config_pkg::*;
(
	input  logic        fclk,
	input  logic        rst_n,
	input  logic        port_wr,
	input  port_sel_t   port_sel,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	output logic [7:0]  p7ffd_raw,
	output logic [7:0]  peff7_raw,
	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	output logic        block1m,
	output logic [5:0]  pent1m_page,
	output logic        pent1m_rom,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0
);

	logic lock_7ffd;

	assign block1m   = peff7_raw[EFF7_BLOCK1M];
	assign lock_7ffd = p7ffd_raw[PAGE_LOCK_BIT] & block1m; // 48k lock only in 128k mode

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_raw <= PAGE_RST;
			peff7_raw <= PAGE_RST;
		end
		else if (port_wr)
		begin
			if (port_sel == sel_7ffd && !lock_7ffd)
				p7ffd_raw <= din; // 2..0 page, 3 screen, 4 rom, 5 lock, 7..6 1M page hi
			if (port_sel == sel_eff7 && !a[12])
				peff7_raw <= din;
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// exported values
	//////////////////////////////////////////////////////////////////////////

	assign p7ffd = {(block1m ? 3'b000 : p7ffd_raw[7:5]), p7ffd_raw[4:0]};
	assign peff7 = block1m ? (peff7_raw & EFF7_1M_MASK) : peff7_raw;

	// pentagon 1M view
	assign pent1m_page   = {p7ffd_raw[7:5], p7ffd_raw[2:0]};
	assign pent1m_rom    = p7ffd_raw[4];
	assign pent1m_1m_on  = ~peff7_raw[EFF7_BLOCK1M]; // active when 1M not blocked
	assign pent1m_ram0_0 = peff7_raw[EFF7_RAM0];

endmodule

// ==== design/port_decoder.sv ====
/*
 * port decoder: low address byte plus shadow state
 * into one port selection and the port hit flag
 */

module port_decoder
	import port_map_pkg::*;
(
	input  logic [15:0] a,
	input  logic        dos,
	input  logic        shadow_en,
	output port_sel_t   port_sel,
	output logic        porthit
);

	logic       shadow;
	logic [7:0] loa;

	assign shadow = dos | shadow_en; // dos rom or forced by BF
	assign loa    = a[7:0];

	always_comb
	begin
		port_sel = sel_none;
		case (loa)
			PORT_FE,
			PORT_F6:
				port_sel = sel_fe;
			PORT_FD:
			begin
				if (!a[15])
					port_sel = sel_7ffd; // BFFD/FFFD belong to AY, not here
			end
			PORT_FC:
			begin
				if (!a[15])
					port_sel = sel_7ffd;
				else
					port_sel = sel_fe; // border alias
			end
			PORT_F7:
			begin
				// EFF7 only outside shadow, xEF7 family
				if (!shadow && a[8])
					port_sel = sel_eff7;
			end
			PORT_BF:      port_sel = sel_bf;
			PORT_BE:      port_sel = sel_be;
			PORT_BD:      port_sel = sel_bd;
			PORT_ULAPLUS: port_sel = sel_ulaplus;
			default:      port_sel = sel_none;
		endcase
	end

	assign porthit = (port_sel != sel_none); // F6 and FC land in sel_fe/sel_7ffd

endmodule

// ==== design/port_map_pkg.sv ====
/*
 * port map: low address bytes of the kept I/O ports,
 * the decoded port selection and the BD/BE readback index
 */

package port_map_pkg;

	//////////////////////////////////////////////////////////////////////////
	// low address bytes
	//////////////////////////////////////////////////////////////////////////

	localparam logic [7:0] PORT_FE      = 8'hFE; // border, beeper, keyboard
	localparam logic [7:0] PORT_F6      = 8'hF6; // FE alias
	localparam logic [7:0] PORT_FC      = 8'hFC; // 7FFD alias, FE alias when a15 set
	localparam logic [7:0] PORT_FD      = 8'hFD; // 7FFD paging
	localparam logic [7:0] PORT_F7      = 8'hF7; // EFF7 paging
	localparam logic [7:0] PORT_BF      = 8'hBF; // evo config
	localparam logic [7:0] PORT_BE      = 8'hBE; // nmi clear, readback
	localparam logic [7:0] PORT_BD      = 8'hBD; // readback and write
	localparam logic [7:0] PORT_ULAPLUS = 8'h3B;

	// one value per kept register port
	typedef enum logic [2:0] {
		sel_none    = 3'd0,
		sel_fe      = 3'd1,
		sel_7ffd    = 3'd2,
		sel_eff7    = 3'd3,
		sel_bf      = 3'd4,
		sel_be      = 3'd5,
		sel_bd      = 3'd6,
		sel_ulaplus = 3'd7
	} port_sel_t;

	// a[12:8] on BD/BE accesses
	typedef enum logic [4:0] {
		bd_p7ffd  = 5'h0A,
		bd_peff7  = 5'h0B,
		bd_border = 5'h0F,
		bd_lobrk  = 5'h10,
		bd_hibrk  = 5'h11
	} bd_index_t;

endpackage

// ==== design/readback_mux.sv ====
/*
 * z80 read data: FE keyboard and tape, BF config,
 * BD/BE indexed readback and the ULAplus data register
 */

module readback_mux
	import port_map_pkg::*;
	import config_pkg::*;
(
	input  logic [15:0] a,
	input  port_sel_t   port_sel,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	input  logic [7:0]  p7ffd_raw,
	input  logic [7:0]  peff7_raw,
	input  logic        shadow_en,
	input  logic        romrw_en,
	input  logic        set_nmi,
	input  logic        brk_ena,
	input  border_t     border,
	input  logic [15:0] brk_addr,
	input  logic [7:0]  up_lastwritten,
	output logic [7:0]  dout,
	output logic        dataout
);

	logic [7:0] bf_byte;
	logic [7:0] bd_byte;

	always_comb
	begin
		bf_byte            = 8'h00; // unused bits read 0
		bf_byte[BF_SHADOW] = shadow_en;
		bf_byte[BF_ROMRW]  = romrw_en;
		bf_byte[BF_NMI]    = set_nmi;
		bf_byte[BF_BRK]    = brk_ena;
	end

	// indexed by a[12:8]
	always_comb
	begin
		case (bd_index_t'(a[12:8]))
			bd_p7ffd:  bd_byte = p7ffd_raw;
			bd_peff7:  bd_byte = peff7_raw;
			bd_border: bd_byte = {4'h0, border};
			bd_lobrk:  bd_byte = brk_addr[7:0];
			bd_hibrk:  bd_byte = brk_addr[15:8];
			default:   bd_byte = 8'hFF;
		endcase
	end

	always_comb
	begin
		case (port_sel)
			sel_fe:      dout = {1'b1, tape_read, 1'b0, keys_in};
			sel_bf:      dout = bf_byte;
			sel_be,
			sel_bd:      dout = bd_byte;
			sel_ulaplus: dout = up_lastwritten;
			default:     dout = 8'hFF; // paging ports are write-only
		endcase
	end

	assign dataout = (port_sel != sel_none) & ~iorq_n & ~rd_n; // drive z80 bus

endmodule

// ==== design/zports.sv ====
/*
 * I/O port block top: strobe sync, decoder, paging and
 * config registers, read data mux
 */

module zports
	import port_map_pkg::*;
	import config_pkg::*;
(
	input  logic        fclk,
	input  logic        rst_n,
	input  logic        zpos,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        dos,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	output logic [7:0]  dout,
	output logic        dataout,
	output logic        porthit,
	output logic        port_wr,
	output logic        port_rd,
	output logic [7:0]  p7ffd_raw,
	output logic [7:0]  peff7_raw,
	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	output logic        block1m,
	output logic [5:0]  pent1m_page,
	output logic        pent1m_rom,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0,
	output logic        shadow_en,
	output logic        romrw_en,
	output logic        set_nmi,
	output logic        brk_ena,
	output logic [15:0] brk_addr,
	output border_t     border,
	output logic        beeper_wr,
	output logic        clr_nmi,
	output logic        up_ena,
	output logic [5:0]  up_paladdr,
	output logic [7:0]  up_paldata,
	output logic        up_palwr,
	output logic [7:0]  up_lastwritten
);

	port_sel_t port_sel;

	bus_strobe_sync u_strobe (
		.fclk, .rst_n, .zpos, .iorq_n, .rd_n, .wr_n, .port_wr, .port_rd
	);

	port_decoder u_decoder (
		.a, .dos, .shadow_en, .port_sel, .porthit
	);

	paging_regs u_paging (
		.fclk, .rst_n, .port_wr, .port_sel, .a, .din,
		.p7ffd_raw, .peff7_raw, .p7ffd, .peff7, .block1m,
		.pent1m_page, .pent1m_rom, .pent1m_1m_on, .pent1m_ram0_0
	);

	evo_config_regs u_config (
		.fclk, .rst_n, .port_wr, .port_sel, .a, .din,
		.shadow_en, .romrw_en, .set_nmi, .brk_ena, .brk_addr, .border,
		.beeper_wr, .clr_nmi,
		.up_ena, .up_paladdr, .up_paldata, .up_palwr, .up_lastwritten
	);

	readback_mux u_readback (
		.a, .port_sel, .iorq_n, .rd_n, .keys_in, .tape_read,
		.p7ffd_raw, .peff7_raw, .shadow_en, .romrw_en, .set_nmi, .brk_ena,
		.border, .brk_addr, .up_lastwritten, .dout, .dataout
	);

endmodule

// ==== files.f ====
design/port_map_pkg.sv
design/config_pkg.sv
design/bus_strobe_sync.sv
design/port_decoder.sv
design/paging_regs.sv
design/evo_config_regs.sv
design/readback_mux.sv
design/zports.sv
verif/zports_checker.sv
verif/zports_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the zports testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module zports_tb -o zports_sim \
	&& ./obj_dir/zports_sim \
	|| { echo "verilator build or simulation run failed"; exit 1; }

// ==== verif/zports_checker.sv ====
/*
 * assertion checker bound to the port block:
 * write/read pulse timing and the 7FFD lock
 */

module zports_checker (
	input logic        fclk,
	input logic        rst_n,
	input logic        zpos,
	input logic [15:0] a,
	input logic        iorq_n,
	input logic        wr_n,
	input logic        port_wr,
	input logic        port_rd,
	input logic        block1m,
	input logic [7:0]  p7ffd_raw
);

	// pulse trails the sampled strobe by 3 clocks
	a_wr_timing: assert property (@(posedge fclk) disable iff (!rst_n)
		port_wr |-> $past(zpos && !iorq_n && !wr_n, 3))
		else $error("port_wr without a write strobe sampled 3 clocks earlier");

	a_wr_rd_excl: assert property (@(posedge fclk) disable iff (!rst_n)
		!(port_wr && port_rd))
		else $error("port_wr and port_rd high together");

	// lock = bit 5 with 1M block on, xxFD/xxFC with a15 low
	a_lock_hold: assert property (@(posedge fclk) disable iff (!rst_n)
		$changed(p7ffd_raw) |-> $past(port_wr && !a[15] && (a[7:1] == 7'h7E)
			&& !(p7ffd_raw[5] && block1m)))
		else $error("p7ffd_raw changed without an unlocked 7FFD write");

endmodule

bind zports zports_checker u_checker (
	.fclk      (fclk),
	.rst_n     (rst_n),
	.zpos      (zpos),
	.a         (a),
	.iorq_n    (iorq_n),
	.wr_n      (wr_n),
	.port_wr   (port_wr),
	.port_rd   (port_rd),
	.block1m   (block1m),
	.p7ffd_raw (p7ffd_raw)
);

// ==== verif/zports_tb.sv ====
/*
 * testbench for the I/O port block: drives z80 I/O cycles
 * and checks registers, strobes and read data
 */

module zports_tb
	import port_map_pkg::*;
	import config_pkg::*;
();

	localparam int NUM_TESTS      = 6;
	localparam int BUS_CYCLES     = 60; // budget per test
	localparam int BUS_CYCLE_TIME = 40; // one io_write, 10 clocks

	logic        fclk;
	logic        rst_n;
	logic        zpos;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        dos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [7:0]  dout;
	logic        dataout;
	logic        porthit;
	logic        port_wr;
	logic        port_rd;
	logic [7:0]  p7ffd_raw;
	logic [7:0]  peff7_raw;
	logic [7:0]  p7ffd;
	logic [7:0]  peff7;
	logic        block1m;
	logic [5:0]  pent1m_page;
	logic        pent1m_rom;
	logic        pent1m_1m_on;
	logic        pent1m_ram0_0;
	logic        shadow_en;
	logic        romrw_en;
	logic        set_nmi;
	logic        brk_ena;
	logic [15:0] brk_addr;
	border_t     border;
	logic        beeper_wr;
	logic        clr_nmi;
	logic        up_ena;
	logic [5:0]  up_paladdr;
	logic [7:0]  up_paldata;
	logic        up_palwr;
	logic [7:0]  up_lastwritten;

	int          beeper_cnt; // strobe pulses seen in the last io_write
	int          nmi_cnt;
	int          palwr_cnt;
	int          wr_cnt;     // port_wr pulses in the last io_write
	logic [31:0] lfsr_state;
	logic [7:0]  eff7_model;  // last EFF7 value that should have landed

	zports u_zports (.*);

	initial
	begin
		fclk = 1'b0;
		forever #2 fclk = ~fclk;
	end

	////////////////////////////////////////////////////////////////////////////
	// random data, reporting and compare tasks
	////////////////////////////////////////////////////////////////////////////

	// galois lfsr, one step per bit
	function automatic logic [7:0] random_bits(input int n);
		logic [7:0] r;
		r = 8'h00;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
			r = {r[6:0], lfsr_state[0]};
		end
		return r;
	endfunction

	task automatic stop_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s, got %02h, expected %02h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_border(input border_t got, input border_t exp, input string what);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s, got %01h, expected %01h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
		begin
			$display("CHECK FAILED at %0t: %s, got %0d pulses, expected %0d", $time, what, got, exp);
			stop_run();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// z80 bus cycles
	////////////////////////////////////////////////////////////////////////////

	task automatic count_strobes();
		if (beeper_wr)
			beeper_cnt++;
		if (clr_nmi)
			nmi_cnt++;
		if (up_palwr)
			palwr_cnt++;
		if (port_wr)
			wr_cnt++;
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		beeper_cnt = 0;
		nmi_cnt    = 0;
		palwr_cnt  = 0;
		wr_cnt     = 0;
		@(negedge fclk);
		a      = addr;
		din    = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		repeat (6)
		begin
			@(negedge fclk);
			count_strobes();
		end
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		repeat (4)
		begin
			@(negedge fclk);
			count_strobes(); // pulse lands inside these 10 clocks
		end
		check_count(wr_cnt, 1, "port_wr per bus write");
	endtask

	task automatic io_read(input logic [15:0] addr, input logic [7:0] exp, input string what);
		int rd_cnt;
		rd_cnt = 0;
		@(negedge fclk);
		a      = addr;
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		@(negedge fclk);
		check_byte(dout, exp, what); // rd_n still low
		check_bit(dataout, 1'b1, "dataout during read");
		check_bit(porthit, 1'b1, "porthit during read");
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		repeat (3)
		begin
			@(negedge fclk);
			if (port_rd)
				rd_cnt++; // read pulse trails the strobe
		end
		check_count(rd_cnt, 1, "port_rd per bus read");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_border();
		logic [7:0] d;
		logic [7:0] r;
		@(negedge fclk);
		a = 16'h00FF; // no port decodes here
		@(negedge fclk);
		check_bit(porthit, 1'b0, "porthit on unused port");
		d = random_bits(8);
		io_write({8'h00, PORT_FE}, d); // a3 set, bright bit off
		check_border(border, {1'b0, d[2:0]}, "border after FE write");
		check_count(beeper_cnt, 1, "beeper_wr on FE");
		d = random_bits(8);
		io_write({8'h00, PORT_F6}, d); // a3 clear
		check_border(border, {1'b1, d[2:0]}, "border after F6 write");
		check_count(beeper_cnt, 0, "beeper_wr on F6 alias");
		io_read({3'b000, bd_border, PORT_BD}, {4'h0, 1'b1, d[2:0]}, "BD border readback");
		r = random_bits(5);
		keys_in = r[4:0];
		r = random_bits(1);
		tape_read = r[0];
		io_read({8'h00, PORT_FE}, {1'b1, tape_read, 1'b0, keys_in}, "FE keyboard read");
	endtask

	task automatic test_7ffd_paging();
		logic [7:0] d;
		logic [7:0] r;
		d = random_bits(8) & 8'hDF; // lock bit clear
		io_write({8'h7F, PORT_FD}, d);
		io_read({3'b000, bd_p7ffd, PORT_BD}, d, "7FFD readback");
		check_byte(p7ffd, d, "p7ffd outside 1M block");
		io_read({8'h7F, PORT_FD}, 8'hFF, "7FFD port read");
		io_write({8'hEF, PORT_F7}, 8'h04); // block1m on
		d = random_bits(8) | 8'h20;
		io_write({8'h7F, PORT_FC}, d); // FC alias, sets lock
		r = random_bits(8);
		io_write({8'h7F, PORT_FD}, r); // must be dropped
		io_read({3'b000, bd_p7ffd, PORT_BD}, d, "7FFD readback while locked");
		check_byte(p7ffd_raw, d, "p7ffd_raw while locked");
		check_byte(p7ffd, {3'b000, d[4:0]}, "p7ffd masked in 1M block");
		check_byte({2'b00, pent1m_page}, {2'b00, d[7:5], d[2:0]}, "pent1m_page");
		check_bit(pent1m_rom, d[4], "pent1m_rom");
	endtask

	task automatic test_eff7_masking();
		logic [7:0] e;
		e = random_bits(8);
		io_write({8'hEF, PORT_F7}, e);
		eff7_model = e;
		io_read({3'b000, bd_peff7, PORT_BD}, e, "EFF7 readback");
		check_byte(peff7_raw, e, "peff7_raw");
		check_byte(peff7, e[2] ? (e & 8'b1011_0001) : e, "peff7 masking");
		check_bit(block1m, e[2], "block1m");
		check_bit(pent1m_1m_on, ~e[2], "pent1m_1m_on");
		check_bit(pent1m_ram0_0, e[3], "pent1m_ram0_0");
		dos = 1'b1;
		io_write({8'hEF, PORT_F7}, ~e); // shadow via dos
		dos = 1'b0;
		io_write({8'hFF, PORT_F7}, ~e); // a12 set
		io_read({3'b000, bd_peff7, PORT_BD}, e, "EFF7 after dos and a12 writes");
	endtask

	task automatic test_bf_config();
		logic [7:0] d;
		d = random_bits(8);
		io_write({8'h00, PORT_BF}, d);
		io_read({8'h00, PORT_BF}, {3'b000, d[4], d[3], 1'b0, d[1], d[0]}, "BF readback");
		check_bit(shadow_en, d[0], "shadow_en");
		check_bit(romrw_en, d[1], "romrw_en");
		check_bit(set_nmi, d[3], "set_nmi");
		check_bit(brk_ena, d[4], "brk_ena");
		io_write({8'h00, PORT_BF}, 8'h01); // shadow on
		io_write({8'hEF, PORT_F7}, ~eff7_model);
		io_read({3'b000, bd_peff7, PORT_BD}, eff7_model, "EFF7 write under shadow_en");
		io_write({8'h00, PORT_BF}, 8'h00);
		io_write({8'h00, PORT_BE}, random_bits(8));
		check_count(nmi_cnt, 1, "clr_nmi on BE");
	endtask

	task automatic test_break_addr();
		logic [7:0] lo;
		logic [7:0] hi;
		lo = random_bits(8);
		hi = random_bits(8);
		io_write({3'b000, bd_lobrk, PORT_BD}, lo);
		io_write({3'b000, bd_hibrk, PORT_BD}, hi);
		check_byte(brk_addr[7:0], lo, "brk_addr low");
		check_byte(brk_addr[15:8], hi, "brk_addr high");
		io_read({3'b000, bd_lobrk, PORT_BD}, lo, "BD break low readback");
		io_read({3'b000, bd_hibrk, PORT_BE}, hi, "BE break high readback");
	endtask

	task automatic test_ulaplus();
		logic [7:0] n;
		logic [7:0] d;
		n = random_bits(6);
		d = random_bits(8);
		io_write({8'hBF, PORT_ULAPLUS}, {ULA_GROUP_PALETTE, n[5:0]});
		io_write({8'hFF, PORT_ULAPLUS}, d);
		check_count(palwr_cnt, 1, "up_palwr on palette data");
		check_byte({2'b00, up_paladdr}, {2'b00, n[5:0]}, "up_paladdr");
		check_byte(up_paldata, {d[4:2], d[7:5], d[1:0]}, "up_paldata reorder");
		check_byte(up_lastwritten, d, "up_lastwritten after palette data");
		io_write({8'hBF, PORT_ULAPLUS}, {ULA_GROUP_MODE, 6'd0});
		io_write({8'hFF, PORT_ULAPLUS}, 8'h01);
		check_count(palwr_cnt, 0, "up_palwr in mode group");
		check_bit(up_ena, 1'b1, "up_ena");
		io_read({8'hFF, PORT_ULAPLUS}, 8'h01, "3B last written");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		lfsr_state = 32'h4cc1afc0;
		eff7_model = 8'h00;
		rst_n      = 1'b0;
		zpos       = 1'b1; // held high, every edge samples
		a          = 16'h0000;
		din        = 8'h00;
		iorq_n     = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		dos        = 1'b0;
		keys_in    = 5'h00;
		tape_read  = 1'b0;
		repeat (3) @(posedge fclk);
		@(negedge fclk);
		rst_n = 1'b1;
		test_border();
		test_7ffd_paging();
		test_eff7_masking();
		test_bf_config();
		test_break_addr();
		test_ulaplus();
		$display("Simulation finished: PASS");
		$finish;
	end

	initial
	begin
		#(NUM_TESTS * BUS_CYCLES * BUS_CYCLE_TIME);
		$display("watchdog expired, tests did not finish at time %0t", $time);
		stop_run();
	end

endmodule
